//--- axis_pkg.sv
// package with default stream widths, output count and output port indices
`default_nettype none

package axis_pkg;

    // default link widths
    // the top level passes its own values down to every block
    localparam int TDATA_BYTES_DEF = 4;    // bytes per beat
    localparam int TDEST_WIDTH_DEF = 4;
    localparam int TUSER_WIDTH_DEF = 8;    // also the width of one extract code
    localparam int TID_WIDTH_DEF   = 4;

    // the extractor always splits into two streams
    localparam int OUTPUTS = 2;

    // output indices
    localparam int PORT_PASS    = 0;       // packets with no table hit
    localparam int PORT_EXTRACT = 1;       // packets whose first tuser is in the table

endpackage

`default_nettype wire

//--- axis_skid_buffer.sv
// two-entry register slice for one AXI4-Stream link with a flat payload
`timescale 1ns/1ns
`default_nettype none

module axis_skid_buffer #(
    parameter int WIDTH = 8
) (
    input  wire              aclk,
    input  wire              rst,
    // upstream side
    input  wire              in_tvalid,
    output wire              in_tready,
    input  wire  [WIDTH-1:0] in_payload,
    // downstream side
    output wire              out_tvalid,
    input  wire              out_tready,
    output wire  [WIDTH-1:0] out_payload
);

    logic             main_valid;     // main entry drives the output
    logic [WIDTH-1:0] main_data;
    logic             skid_valid;     // beat caught while the output stalled
    logic [WIDTH-1:0] skid_data;
    logic             ready_q;

    logic main_valid_d;
    logic skid_valid_d;
    logic load_from_in;
    logic load_from_skid;
    logic load_skid;
    logic in_fire;

    // ready_q low whenever skid is full, so no beat arrives with the skid entry taken
    assign in_fire = in_tvalid && ready_q;

    always_comb begin
        main_valid_d   = main_valid;
        skid_valid_d   = skid_valid;
        load_from_in   = 1'b0;
        load_from_skid = 1'b0;
        load_skid      = 1'b0;
        if (!main_valid || out_tready) begin
            // main entry is free or drains this cycle
            if (skid_valid) begin
                main_valid_d   = 1'b1;
                skid_valid_d   = 1'b0;
                load_from_skid = 1'b1;  // parked beat goes first
            end else begin
                main_valid_d = in_fire;
                load_from_in = in_fire;
            end
        end else if (in_fire) begin
            skid_valid_d = 1'b1;        // output stalled, park the beat
            load_skid    = 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            ready_q    <= 1'b0;
        end else begin
            main_valid <= main_valid_d;
            skid_valid <= skid_valid_d;
            ready_q    <= !skid_valid_d;    // falls the cycle after the skid fills
        end
    end

    always_ff @(posedge aclk) begin
        if (load_from_skid) begin
            main_data <= skid_data;
        end else if (load_from_in) begin
            main_data <= in_payload;
        end
        if (load_skid) begin
            skid_data <= in_payload;
        end
    end

    assign in_tready   = ready_q;
    assign out_tvalid  = main_valid;
    assign out_payload = main_data;

endmodule

`default_nettype wire

//--- axis_extract_match.sv
// extract table lookup that flags a TUSER code found among the table entries
`timescale 1ns/1ns
`default_nettype none

module axis_extract_match #(
    parameter int PACKETS     = 4,
    parameter int TUSER_WIDTH = axis_pkg::TUSER_WIDTH_DEF,
    parameter logic [PACKETS-1:0][TUSER_WIDTH-1:0] EXTRACT = '0
) (
    input  wire  [TUSER_WIDTH-1:0] tuser,
    output wire                    hit
);

    logic [PACKETS-1:0] entry_hit;    // one equality per table entry

    // every entry is compared in parallel
    always_comb begin
        for (int i = 0; i < PACKETS; i++) begin
            entry_hit[i] = (tuser == EXTRACT[i]);
        end
    end

    // duplicate codes in the table are harmless here
    assign hit = |entry_hit;

endmodule

`default_nettype wire

//--- axis_extract.sv
// packet demultiplexer with first-beat tracking, route hold and the table matcher
`timescale 1ns/1ns
`default_nettype none

module axis_extract #(
    parameter int PACKETS     = 4,
    parameter int TDATA_BYTES = axis_pkg::TDATA_BYTES_DEF,
    parameter int TDEST_WIDTH = axis_pkg::TDEST_WIDTH_DEF,
    parameter int TUSER_WIDTH = axis_pkg::TUSER_WIDTH_DEF,
    parameter int TID_WIDTH   = axis_pkg::TID_WIDTH_DEF,
    parameter logic [PACKETS-1:0][TUSER_WIDTH-1:0] EXTRACT = '0
) (
    input  wire                              aclk,
    input  wire                              rst,
    // input stream
    input  wire                              in_tvalid,
    input  wire                              in_tlast,
    input  wire  [TDATA_BYTES-1:0][7:0]      in_tdata,
    input  wire  [TDATA_BYTES-1:0]           in_tstrb,
    input  wire  [TDATA_BYTES-1:0]           in_tkeep,
    input  wire  [TDEST_WIDTH-1:0]           in_tdest,
    input  wire  [TUSER_WIDTH-1:0]           in_tuser,
    input  wire  [TID_WIDTH-1:0]             in_tid,
    output wire                              in_tready,
    // output streams, payload shared by both
    output logic [axis_pkg::OUTPUTS-1:0]     out_tvalid,
    output wire                              out_tlast,
    output wire  [TDATA_BYTES-1:0][7:0]      out_tdata,
    output wire  [TDATA_BYTES-1:0]           out_tstrb,
    output wire  [TDATA_BYTES-1:0]           out_tkeep,
    output wire  [TDEST_WIDTH-1:0]           out_tdest,
    output wire  [TUSER_WIDTH-1:0]           out_tuser,
    output wire  [TID_WIDTH-1:0]             out_tid,
    input  wire  [axis_pkg::OUTPUTS-1:0]     out_tready
);

    import axis_pkg::*;

    localparam int SEL_WIDTH = $clog2(OUTPUTS);

    logic                 hit;
    logic                 first_q;      // next accepted beat opens a packet
    logic [SEL_WIDTH-1:0] route_q;      // port held until tlast
    logic [SEL_WIDTH-1:0] route;
    logic                 in_fire;

    axis_extract_match #(
        .PACKETS     (PACKETS),
        .TUSER_WIDTH (TUSER_WIDTH),
        .EXTRACT     (EXTRACT)
    ) u_match (
        .tuser (in_tuser),
        .hit   (hit)
    );

    // the lookup only counts on the first beat, later tuser values are ignored
    always_comb begin
        if (first_q) begin
            route = hit ? SEL_WIDTH'(PORT_EXTRACT) : SEL_WIDTH'(PORT_PASS);
        end else begin
            route = route_q;
        end
    end

    always_comb begin
        for (int k = 0; k < OUTPUTS; k++) begin
            out_tvalid[k] = in_tvalid && (route == SEL_WIDTH'(k));
        end
    end

    assign in_tready = out_tready[route];      // only the routed port may stall us
    assign in_fire   = in_tvalid && in_tready;

    always_ff @(posedge aclk) begin
        if (rst) begin
            first_q <= 1'b1;
            route_q <= SEL_WIDTH'(PORT_PASS);
        end else if (in_fire) begin
            first_q <= in_tlast;
            route_q <= route;   // unchanged after the first beat
        end
    end

    assign out_tlast = in_tlast;
    assign out_tdata = in_tdata;
    assign out_tstrb = in_tstrb;
    assign out_tkeep = in_tkeep;
    assign out_tdest = in_tdest;
    assign out_tuser = in_tuser;
    assign out_tid   = in_tid;

endmodule

`default_nettype wire

//--- axis_extract_top.sv
// top level with input slice, packet extractor and one output slice per port
`timescale 1ns/1ns
`default_nettype none

module axis_extract_top #(
    parameter int PACKETS     = 4,
    parameter int TDATA_BYTES = axis_pkg::TDATA_BYTES_DEF,
    parameter int TDEST_WIDTH = axis_pkg::TDEST_WIDTH_DEF,
    parameter int TUSER_WIDTH = axis_pkg::TUSER_WIDTH_DEF,
    parameter int TID_WIDTH   = axis_pkg::TID_WIDTH_DEF,
    parameter logic [PACKETS-1:0][TUSER_WIDTH-1:0] EXTRACT = init_extract()
) (
    input  wire                                               aclk,
    input  wire                                               rst,
    // rx stream
    input  wire                                               rx_tvalid,
    input  wire                                               rx_tlast,
    input  wire  [TDATA_BYTES-1:0][7:0]                       rx_tdata,
    input  wire  [TDATA_BYTES-1:0]                            rx_tstrb,
    input  wire  [TDATA_BYTES-1:0]                            rx_tkeep,
    input  wire  [TDEST_WIDTH-1:0]                            rx_tdest,
    input  wire  [TUSER_WIDTH-1:0]                            rx_tuser,
    input  wire  [TID_WIDTH-1:0]                              rx_tid,
    output wire                                               rx_tready,
    // tx streams, index 0 pass and index 1 extract
    output wire  [axis_pkg::OUTPUTS-1:0]                      tx_tvalid,
    output wire  [axis_pkg::OUTPUTS-1:0]                      tx_tlast,
    output wire  [axis_pkg::OUTPUTS-1:0][TDATA_BYTES-1:0][7:0] tx_tdata,
    output wire  [axis_pkg::OUTPUTS-1:0][TDATA_BYTES-1:0]     tx_tstrb,
    output wire  [axis_pkg::OUTPUTS-1:0][TDATA_BYTES-1:0]     tx_tkeep,
    output wire  [axis_pkg::OUTPUTS-1:0][TDEST_WIDTH-1:0]     tx_tdest,
    output wire  [axis_pkg::OUTPUTS-1:0][TUSER_WIDTH-1:0]     tx_tuser,
    output wire  [axis_pkg::OUTPUTS-1:0][TID_WIDTH-1:0]       tx_tid,
    input  wire  [axis_pkg::OUTPUTS-1:0]                      tx_tready
);

    import axis_pkg::*;

    // tlast, tdata, tstrb, tkeep, tdest, tuser and tid side by side
    localparam int PAYLOAD_WIDTH = 1 + 8 * TDATA_BYTES + 2 * TDATA_BYTES +
                                   TDEST_WIDTH + TUSER_WIDTH + TID_WIDTH;

    // default table holds the codes 0 up to PACKETS-1
    function automatic logic [PACKETS-1:0][TUSER_WIDTH-1:0] init_extract();
        logic [PACKETS-1:0][TUSER_WIDTH-1:0] codes;
        codes = '0;
        for (int i = 0; i < PACKETS; i++) begin
            codes[i] = TUSER_WIDTH'(i);
        end
        return codes;
    endfunction

    logic [PAYLOAD_WIDTH-1:0] rx_payload;

    // between the input slice and the extractor
    logic                     mid_tvalid;
    logic                     mid_tready;
    logic [PAYLOAD_WIDTH-1:0] mid_payload;
    logic                     mid_tlast;
    logic [TDATA_BYTES-1:0][7:0] mid_tdata;
    logic [TDATA_BYTES-1:0]   mid_tstrb;
    logic [TDATA_BYTES-1:0]   mid_tkeep;
    logic [TDEST_WIDTH-1:0]   mid_tdest;
    logic [TUSER_WIDTH-1:0]   mid_tuser;
    logic [TID_WIDTH-1:0]     mid_tid;

    // between the extractor and the output slices
    logic [OUTPUTS-1:0]       ext_tvalid;
    wire  [OUTPUTS-1:0]       ext_tready;
    logic                     ext_tlast;
    logic [TDATA_BYTES-1:0][7:0] ext_tdata;
    logic [TDATA_BYTES-1:0]   ext_tstrb;
    logic [TDATA_BYTES-1:0]   ext_tkeep;
    logic [TDEST_WIDTH-1:0]   ext_tdest;
    logic [TUSER_WIDTH-1:0]   ext_tuser;
    logic [TID_WIDTH-1:0]     ext_tid;
    logic [PAYLOAD_WIDTH-1:0] ext_payload;

    wire  [OUTPUTS-1:0][PAYLOAD_WIDTH-1:0] tx_payload;

    assign rx_payload = {rx_tlast, rx_tdata, rx_tstrb, rx_tkeep, rx_tdest, rx_tuser, rx_tid};

    axis_skid_buffer #(
        .WIDTH (PAYLOAD_WIDTH)
    ) u_rx_slice (
        .aclk        (aclk),
        .rst         (rst),
        .in_tvalid   (rx_tvalid),
        .in_tready   (rx_tready),
        .in_payload  (rx_payload),
        .out_tvalid  (mid_tvalid),
        .out_tready  (mid_tready),
        .out_payload (mid_payload)
    );

    assign {mid_tlast, mid_tdata, mid_tstrb, mid_tkeep, mid_tdest, mid_tuser, mid_tid} =
        mid_payload;

    axis_extract #(
        .PACKETS     (PACKETS),
        .TDATA_BYTES (TDATA_BYTES),
        .TDEST_WIDTH (TDEST_WIDTH),
        .TUSER_WIDTH (TUSER_WIDTH),
        .TID_WIDTH   (TID_WIDTH),
        .EXTRACT     (EXTRACT)
    ) u_extract (
        .aclk       (aclk),
        .rst        (rst),
        .in_tvalid  (mid_tvalid),
        .in_tlast   (mid_tlast),
        .in_tdata   (mid_tdata),
        .in_tstrb   (mid_tstrb),
        .in_tkeep   (mid_tkeep),
        .in_tdest   (mid_tdest),
        .in_tuser   (mid_tuser),
        .in_tid     (mid_tid),
        .in_tready  (mid_tready),
        .out_tvalid (ext_tvalid),
        .out_tlast  (ext_tlast),
        .out_tdata  (ext_tdata),
        .out_tstrb  (ext_tstrb),
        .out_tkeep  (ext_tkeep),
        .out_tdest  (ext_tdest),
        .out_tuser  (ext_tuser),
        .out_tid    (ext_tid),
        .out_tready (ext_tready)
    );

    assign ext_payload = {ext_tlast, ext_tdata, ext_tstrb, ext_tkeep,
                          ext_tdest, ext_tuser, ext_tid};

    // both slices see the same payload, tvalid decides which one takes it
    axis_skid_buffer #(
        .WIDTH (PAYLOAD_WIDTH)
    ) u_tx_slice [OUTPUTS-1:0] (
        .aclk        (aclk),
        .rst         (rst),
        .in_tvalid   (ext_tvalid),
        .in_tready   (ext_tready),
        .in_payload  ({OUTPUTS{ext_payload}}),
        .out_tvalid  (tx_tvalid),
        .out_tready  (tx_tready),
        .out_payload (tx_payload)
    );

    genvar k;
    generate
        for (k = 0; k < OUTPUTS; k++) begin : g_tx_unpack
            assign {tx_tlast[k], tx_tdata[k], tx_tstrb[k], tx_tkeep[k],
                    tx_tdest[k], tx_tuser[k], tx_tid[k]} = tx_payload[k];
        end
    endgenerate

endmodule

`default_nettype wire

//--- tb_axis_extract_assert.sv
// handshake assertions on the extractor top-level ports and their bind into the top level
`timescale 1ns/1ns
`default_nettype none

module tb_axis_extract_assert #(
    parameter int WIDTH = 57
) (
    input wire                  aclk,
    input wire                  rst,
    input wire                  rx_tvalid,
    input wire                  rx_tready,
    input wire [WIDTH-1:0]      rx_payload,
    input wire [1:0]            tx_tvalid,
    input wire [1:0]            tx_tready,
    input wire [1:0][WIDTH-1:0] tx_payload
);

    a_reset_idle: assert property (@(posedge aclk) rst |=> tx_tvalid == 2'b00)
        else $error("tx_tvalid high in the cycle after reset");

    // a stalled rx beat stays put
    a_rx_hold: assert property (@(posedge aclk) disable iff (rst)
        rx_tvalid && !rx_tready |=> rx_tvalid && $stable(rx_payload))
        else $error("rx beat dropped or changed while stalled");

    genvar k;
    generate
        for (k = 0; k < 2; k++) begin : g_tx
            a_tx_hold: assert property (@(posedge aclk) disable iff (rst)
                tx_tvalid[k] && !tx_tready[k] |=> tx_tvalid[k] && $stable(tx_payload[k]))
                else $error("tx beat on port %0d dropped or changed while stalled", k);
        end
    endgenerate

endmodule

bind axis_extract_top tb_axis_extract_assert #(
    .WIDTH (PAYLOAD_WIDTH)
) u_assert (
    .aclk       (aclk),
    .rst        (rst),
    .rx_tvalid  (rx_tvalid),
    .rx_tready  (rx_tready),
    .rx_payload (rx_payload),
    .tx_tvalid  (tx_tvalid),
    .tx_tready  (tx_tready),
    .tx_payload (tx_payload)
);

`default_nettype wire

//--- tb_axis_extract.sv
// directed testbench for the packet extractor with clock, reset, driver, scoreboards and timeout
`timescale 1ns/1ns
`default_nettype none

module tb_axis_extract;

    localparam int BEAT_W      = 57;    // tlast, tdata, tstrb, tkeep, tdest, tuser, tid
    localparam int TOTAL_BEATS = 300;   // upper bound of beats sent by all tests together
    localparam int CYCLE_LIMIT = 20 * TOTAL_BEATS + 200;

    logic             aclk;
    logic             rst;
    logic             rx_tvalid;
    logic             rx_tlast;
    logic [31:0]      rx_tdata;
    logic [3:0]       rx_tstrb;
    logic [3:0]       rx_tkeep;
    logic [3:0]       rx_tdest;
    logic [7:0]       rx_tuser;
    logic [3:0]       rx_tid;
    wire              rx_tready;
    wire  [1:0]       tx_tvalid;
    wire  [1:0]       tx_tlast;
    wire  [1:0][31:0] tx_tdata;
    wire  [1:0][3:0]  tx_tstrb;
    wire  [1:0][3:0]  tx_tkeep;
    wire  [1:0][3:0]  tx_tdest;
    wire  [1:0][7:0]  tx_tuser;
    wire  [1:0][3:0]  tx_tid;
    logic [1:0]       tx_tready = 2'b00;

    logic [1:0]        hold_ready = 2'b00;  // port held at tready 0
    logic [1:0]        rand_ready = 2'b00;  // port with random tready
    logic [BEAT_W-1:0] exp_q0 [$];          // pass port scoreboard
    logic [BEAT_W-1:0] exp_q1 [$];          // extract port scoreboard
    integer            seed = 32'h4900_9a36;
    int                cycles = 0;
    logic [31:0]       data_cnt = 32'd0;
    string             test_name = "reset";

    axis_extract_top u_dut (.*);

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            abort_run("timeout, the DUT stopped delivering beats");
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // tready driver and scoreboard that pops each beat before the rising edge that moves it
    always @(negedge aclk) begin
        logic [BEAT_W-1:0] got;
        logic [BEAT_W-1:0] want;
        integer            r;
        for (int k = 0; k < 2; k++) begin
            r = 1;
            if (rand_ready[k]) begin
                r = $random(seed);
            end
            tx_tready[k] = !hold_ready[k] && r[0];
            if (!rst && tx_tvalid[k] && tx_tready[k]) begin
                got = {tx_tlast[k], tx_tdata[k], tx_tstrb[k], tx_tkeep[k],
                       tx_tdest[k], tx_tuser[k], tx_tid[k]};
                if ((k == 0 && exp_q0.size() == 0) || (k == 1 && exp_q1.size() == 0)) begin
                    abort_run($sformatf("beat on port %0d where no packet was expected", k));
                end else begin
                    if (k == 0) begin
                        want = exp_q0.pop_front();
                    end else begin
                        want = exp_q1.pop_front();
                    end
                    check($sformatf("%s port %0d", test_name, k), 64'(want), 64'(got));
                end
            end
        end
    end

    function automatic int expected_port(input logic [7:0] code);
        return (code < 8'd4) ? 1 : 0;   // table holds codes 0 to 3
    endfunction

    // starts on a falling edge and returns on the falling edge after the transfer
    task automatic put_beat(input logic [BEAT_W-1:0] beat);
        {rx_tlast, rx_tdata, rx_tstrb, rx_tkeep, rx_tdest, rx_tuser, rx_tid} = beat;
        rx_tvalid = 1'b1;
        while (!rx_tready) begin
            @(negedge aclk);
        end
        @(negedge aclk);
    endtask

    task automatic send_packet(input logic [7:0] tuser, input logic [7:0] rest_tuser,
                               input int length, input logic [3:0] tid,
                               input logic [3:0] tdest);
        logic [BEAT_W-1:0] beat;
        logic              last;
        logic [3:0]        keep;
        for (int i = 0; i < length; i++) begin
            last = (i == length - 1);
            keep = last ? 4'h7 : 4'hf;
            beat = {last, data_cnt, keep & data_cnt[3:0], keep, tdest,
                    (i == 0) ? tuser : rest_tuser, tid};
            data_cnt = data_cnt + 1;
            if (expected_port(tuser) == 1) begin
                exp_q1.push_back(beat);     // route follows the first beat only
            end else begin
                exp_q0.push_back(beat);
            end
            put_beat(beat);
        end
        rx_tvalid = 1'b0;
    endtask

    task automatic set_ready(input logic [1:0] hold, input logic [1:0] rnd);
        @(posedge aclk);
        hold_ready = hold;
        rand_ready = rnd;
        @(negedge aclk);
    endtask

    task automatic wait_drained(input int max_cycles, output bit drained);
        int n;
        n = 0;
        drained = 1'b0;
        while (!drained && n < max_cycles) begin
            @(posedge aclk);
            drained = (exp_q0.size() == 0) && (exp_q1.size() == 0);
            n++;
        end
        @(negedge aclk);
    endtask

    task automatic drain_or_abort();
        bit ok;
        wait_drained(2000, ok);
        if (!ok) begin
            abort_run($sformatf("%s left beats undelivered", test_name));
        end
    endtask

    task automatic test_routing();
        test_name = "routing";
        set_ready(2'b00, 2'b00);
        send_packet(8'd0, 8'd0, 3, 4'h1, 4'h2);
        send_packet(8'd3, 8'd3, 5, 4'h2, 4'h5);
        send_packet(8'd7, 8'd7, 2, 4'h3, 4'h9);
        send_packet(8'd200, 8'd200, 4, 4'h4, 4'hc);
        drain_or_abort();
    endtask

    task automatic test_route_hold();
        test_name = "route_hold";
        set_ready(2'b00, 2'b00);
        send_packet(8'd2, 8'd9, 4, 4'h5, 4'h1);
        send_packet(8'd9, 8'd2, 4, 4'h6, 4'h3);
        drain_or_abort();
    endtask

    task automatic test_single_beats();
        logic [7:0] code;
        test_name = "single_beats";
        set_ready(2'b00, 2'b00);
        for (int i = 0; i < 12; i++) begin
            code = (i % 2 == 0) ? 8'((i / 2) % 4) : 8'(50 + i);  // classes alternate
            send_packet(code, code, 1, 4'(i), 4'(15 - i));
        end
        drain_or_abort();
    endtask

    task automatic test_backpressure();
        logic [7:0]        codes [40];
        int                lens [40];
        integer            r;
        logic [BEAT_W-1:0] held;
        test_name = "backpressure";
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            codes[i] = r[0] ? {6'd0, r[2:1]} : {1'b1, r[8:2]};
            lens[i]  = 1 + int'(r[11:9]) % 6;
        end
        set_ready(2'b00, 2'b11);
        for (int i = 0; i < 40; i++) begin
            send_packet(codes[i], codes[i], lens[i], 4'(i), 4'(i + 3));
        end
        drain_or_abort();
        // extract port stalled while the pass port keeps flowing
        test_name = "port_stall";
        set_ready(2'b10, 2'b00);
        send_packet(8'd2, 8'd2, 2, 4'h7, 4'h7);
        send_packet(8'd77, 8'd77, 3, 4'h8, 4'h8);
        send_packet(8'd78, 8'd78, 3, 4'h9, 4'h9);
        do begin
            @(posedge aclk);
        end while (exp_q0.size() != 0);
        @(negedge aclk);
        check("port_stall tvalid", 64'd1, 64'(tx_tvalid[1]));
        held = {tx_tlast[1], tx_tdata[1], tx_tstrb[1], tx_tkeep[1],
                tx_tdest[1], tx_tuser[1], tx_tid[1]};
        check("port_stall held beat", 64'(exp_q1[0]), 64'(held));
        set_ready(2'b00, 2'b00);
        drain_or_abort();
    endtask

    task automatic test_reset();
        test_name = "reset_mid_packet";
        set_ready(2'b11, 2'b00);
        for (int i = 0; i < 3; i++) begin
            put_beat({1'b0, data_cnt, 4'hf, 4'hf, 4'h0, 8'd1, 4'h0});  // never finished
            data_cnt = data_cnt + 1;
        end
        rx_tvalid = 1'b0;
        rst = 1'b1;
        repeat (2) @(negedge aclk);
        rst = 1'b0;
        exp_q0.delete();
        exp_q1.delete();
        @(negedge aclk);
        check("reset_mid_packet tx_tvalid", 64'd0, 64'(tx_tvalid));
        set_ready(2'b00, 2'b00);
        send_packet(8'd7, 8'd7, 3, 4'ha, 4'h4);   // fresh first beat after reset
        send_packet(8'd1, 8'd1, 2, 4'hb, 4'h5);
        drain_or_abort();
    endtask

    initial begin
        bit ok;
        rst       = 1'b1;
        rx_tvalid = 1'b0;
        rx_tlast  = 1'b0;
        rx_tdata  = '0;
        rx_tstrb  = '0;
        rx_tkeep  = '0;
        rx_tdest  = '0;
        rx_tuser  = '0;
        rx_tid    = '0;
        repeat (2) @(negedge aclk);
        rst = 1'b0;
        test_routing();
        test_route_hold();
        test_single_beats();
        test_backpressure();
        test_reset();
        test_name = "end_of_run";
        wait_drained(200, ok);
        if (ok) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            abort_run("scoreboards still hold beats at the end of the run");
        end
    end

endmodule

`default_nettype wire

//--- sim.f
axis_pkg.sv
axis_skid_buffer.sv
axis_extract_match.sv
axis_extract.sv
axis_extract_top.sv
tb_axis_extract_assert.sv
tb_axis_extract.sv

//--- Makefile
# Verilator flow for the AXI4-Stream packet extractor
VERILATOR  ?= verilator
TOP        := tb_axis_extract
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only when the pass message shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
